//--- rtl/creator_pkg.sv
package creator_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------
  localparam int ADDR_WIDTH    = 15;
  localparam int DATA_WIDTH    = 16;
  localparam int SLV_SEL_WIDTH = 3;

  typedef logic [ADDR_WIDTH-1:0]    addr_t;
  typedef logic [DATA_WIDTH-1:0]    word_t;
  typedef logic [3:0]               reg_off_t;
  typedef logic [SLV_SEL_WIDTH-1:0] slv_sel_t;

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  // Config block at byte 0x0000, GPIO at 0x4000
  localparam slv_sel_t SEL_CONFIG = 3'b000;
  localparam slv_sel_t SEL_GPIO   = 3'b100;

  // Config register offsets, version LSW first
  localparam reg_off_t CFG_VERSION0   = 4'd0;
  localparam reg_off_t CFG_VERSION1   = 4'd1;
  localparam reg_off_t CFG_VERSION2   = 4'd2;
  localparam reg_off_t CFG_VERSION3   = 4'd3;
  localparam reg_off_t CFG_MIC_GAIN   = 4'd4;
  localparam reg_off_t CFG_DAC_VOLUME = 4'd5;
  localparam reg_off_t CFG_DAC_FLAGS  = 4'd6;

  // GPIO register offsets
  localparam reg_off_t GPIO_DIR = 4'd0;
  localparam reg_off_t GPIO_OUT = 4'd1;
  localparam reg_off_t GPIO_IN  = 4'd2;

  // ----------------------------------------
  // Bus and configuration structs
  // ----------------------------------------
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    word_t dat;
  } bus_req_t;

  typedef struct packed {
    logic  ack;
    word_t dat;
  } bus_rsp_t;

  typedef struct packed {
    word_t mic_gain;
    word_t dac_volume;
    logic  dac_mute;
    logic  dac_hp_nspk;
  } dac_cfg_t;

endpackage

//--- rtl/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  creator_pkg::bus_req_t m0_req_i,
  input  creator_pkg::bus_req_t m1_req_i,
  output creator_pkg::bus_rsp_t m0_rsp_o,
  output creator_pkg::bus_rsp_t m1_rsp_o,
  output creator_pkg::bus_req_t bus_req_o,
  input  creator_pkg::bus_rsp_t bus_rsp_i
);

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_M0,
    ARB_M1
  } arb_state_t;

  arb_state_t state_q;
  arb_state_t state_d;
  // Set when master 1 had the bus most recently
  logic       last_m1_q;

  // ----------------------------------------
  // Grant FSM
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ARB_IDLE: begin
        if (m0_req_i.cyc && m1_req_i.cyc) begin
          // Both waiting, serve the one that went before last
          state_d = last_m1_q ? ARB_M0 : ARB_M1;
        end else if (m0_req_i.cyc) begin
          state_d = ARB_M0;
        end else if (m1_req_i.cyc) begin
          state_d = ARB_M1;
        end
      end
      ARB_M0: begin
        if (!m0_req_i.cyc) begin
          state_d = ARB_IDLE;
        end
      end
      ARB_M1: begin
        if (!m1_req_i.cyc) begin
          state_d = ARB_IDLE;
        end
      end
      default: state_d = ARB_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q   <= ARB_IDLE;
      last_m1_q <= 1'b1;
    end else begin
      state_q <= state_d;
      if (state_q == ARB_IDLE && state_d != ARB_IDLE) begin
        last_m1_q <= (state_d == ARB_M1);
      end
    end
  end

  // ----------------------------------------
  // Request mux and response steering
  // ----------------------------------------
  always_comb begin
    bus_req_o = '0;
    m0_rsp_o  = '0;
    m1_rsp_o  = '0;
    case (state_q)
      ARB_M0: begin
        bus_req_o = m0_req_i;
        m0_rsp_o  = bus_rsp_i;
      end
      ARB_M1: begin
        bus_req_o = m1_req_i;
        m1_rsp_o  = bus_rsp_i;
      end
      default: bus_req_o = '0;
    endcase
  end

  a_single_master_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(m0_rsp_o.ack && m1_rsp_o.ack));

endmodule

//--- rtl/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  creator_pkg::bus_req_t bus_req_i,
  output creator_pkg::bus_rsp_t bus_rsp_o,
  output creator_pkg::bus_req_t cfg_req_o,
  output creator_pkg::bus_req_t gpio_req_o,
  input  creator_pkg::bus_rsp_t cfg_rsp_i,
  input  creator_pkg::bus_rsp_t gpio_rsp_i
);

  creator_pkg::slv_sel_t slv_sel;
  logic                  hit_cfg;
  logic                  hit_gpio;
  logic                  hit_none;
  logic                  unmapped_ack_q;

  // Top address bits pick the slave
  assign slv_sel  = bus_req_i.adr[creator_pkg::ADDR_WIDTH-1 -: creator_pkg::SLV_SEL_WIDTH];
  assign hit_cfg  = (slv_sel == creator_pkg::SEL_CONFIG);
  assign hit_gpio = (slv_sel == creator_pkg::SEL_GPIO);
  assign hit_none = !hit_cfg && !hit_gpio;

  // ----------------------------------------
  // Request fan-out
  // ----------------------------------------
  // cyc and payload go to both slaves, stb only to the one addressed
  always_comb begin
    cfg_req_o      = bus_req_i;
    gpio_req_o     = bus_req_i;
    cfg_req_o.stb  = bus_req_i.stb && hit_cfg;
    gpio_req_o.stb = bus_req_i.stb && hit_gpio;
  end

  // ----------------------------------------
  // Unmapped region
  // ----------------------------------------
  // Same one-cycle ack as a real slave so the master never hangs
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      unmapped_ack_q <= 1'b0;
    end else begin
      unmapped_ack_q <= bus_req_i.cyc && bus_req_i.stb && hit_none && !unmapped_ack_q;
    end
  end

  // ----------------------------------------
  // Response combining
  // ----------------------------------------
  always_comb begin
    if (hit_cfg) begin
      bus_rsp_o = cfg_rsp_i;
    end else if (hit_gpio) begin
      bus_rsp_o = gpio_rsp_i;
    end else begin
      bus_rsp_o.ack = unmapped_ack_q;
      bus_rsp_o.dat = '0;
    end
  end

  a_one_slave_strobe: assert property (@(posedge clk) disable iff (!rst_n_i)
    $onehot0({cfg_req_o.stb, gpio_req_o.stb}));

endmodule

//--- rtl/config_regs.sv
`timescale 1ns/1ps

module config_regs #(
  parameter logic [63:0]        VERSION      = 64'hBAD2_6032_000A_0001,
  parameter creator_pkg::word_t GAIN_DEFAULT = 16'd3,
  parameter creator_pkg::word_t VOLUME_INIT  = 16'd15
) (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  creator_pkg::bus_req_t req_i,
  output creator_pkg::bus_rsp_t rsp_o,
  output creator_pkg::dac_cfg_t dac_cfg_o
);

  creator_pkg::reg_off_t offset;
  logic                  access;
  creator_pkg::word_t    rd_data;

  creator_pkg::word_t    gain_q;
  creator_pkg::word_t    volume_q;
  logic                  mute_q;
  logic                  hp_nspk_q;
  logic                  ack_q;
  creator_pkg::word_t    rd_data_q;

  assign offset = req_i.adr[3:0];
  // One access per cycle, the ack cycle itself is not a new access
  assign access = req_i.cyc && req_i.stb && !ack_q;

  // ----------------------------------------
  // Read mux
  // ----------------------------------------
  always_comb begin
    case (offset)
      creator_pkg::CFG_VERSION0:   rd_data = VERSION[15:0];
      creator_pkg::CFG_VERSION1:   rd_data = VERSION[31:16];
      creator_pkg::CFG_VERSION2:   rd_data = VERSION[47:32];
      creator_pkg::CFG_VERSION3:   rd_data = VERSION[63:48];
      creator_pkg::CFG_MIC_GAIN:   rd_data = gain_q;
      creator_pkg::CFG_DAC_VOLUME: rd_data = volume_q;
      creator_pkg::CFG_DAC_FLAGS:  rd_data = {14'd0, hp_nspk_q, mute_q};
      default:                     rd_data = '0;
    endcase
  end

  // ----------------------------------------
  // Writable registers
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      gain_q    <= GAIN_DEFAULT;
      volume_q  <= VOLUME_INIT;
      mute_q    <= 1'b0;
      hp_nspk_q <= 1'b0;
    end else if (access && req_i.we) begin
      case (offset)
        creator_pkg::CFG_MIC_GAIN:   gain_q <= req_i.dat;
        creator_pkg::CFG_DAC_VOLUME: volume_q <= req_i.dat;
        creator_pkg::CFG_DAC_FLAGS: begin
          mute_q    <= req_i.dat[0];
          hp_nspk_q <= req_i.dat[1];
        end
        // Version words and spare offsets are read-only
        default: ;
      endcase
    end
  end

  // ----------------------------------------
  // Acknowledge
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // Captured with the ack so data is valid in the ack cycle
  always_ff @(posedge clk) begin
    rd_data_q <= rd_data;
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.dat = rd_data_q;

  assign dac_cfg_o.mic_gain    = gain_q;
  assign dac_cfg_o.dac_volume  = volume_q;
  assign dac_cfg_o.dac_mute    = mute_q;
  assign dac_cfg_o.dac_hp_nspk = hp_nspk_q;

  a_ack_after_strobe: assert property (@(posedge clk) disable iff (!rst_n_i)
    ack_q |-> $past(req_i.cyc && req_i.stb));

endmodule

//--- rtl/gpio_port.sv
`timescale 1ns/1ps

module gpio_port #(
  parameter int GPIO_WIDTH = 16
) (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  creator_pkg::bus_req_t req_i,
  output creator_pkg::bus_rsp_t rsp_o,
  input  logic [GPIO_WIDTH-1:0] gpio_in_i,
  output logic [GPIO_WIDTH-1:0] gpio_out_o,
  output logic [GPIO_WIDTH-1:0] gpio_oe_o
);

  creator_pkg::reg_off_t offset;
  logic                  access;
  creator_pkg::word_t    rd_data;

  logic [GPIO_WIDTH-1:0] dir_q;
  logic [GPIO_WIDTH-1:0] out_q;
  logic [GPIO_WIDTH-1:0] in_meta_q;
  logic [GPIO_WIDTH-1:0] in_sync_q;
  logic                  ack_q;
  creator_pkg::word_t    rd_data_q;

  assign offset = req_i.adr[3:0];
  assign access = req_i.cyc && req_i.stb && !ack_q;

  // Two-stage input synchronizer
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
    end else begin
      in_meta_q <= gpio_in_i;
      in_sync_q <= in_meta_q;
    end
  end

  // ----------------------------------------
  // Register access
  // ----------------------------------------
  always_comb begin
    rd_data = '0;
    case (offset)
      creator_pkg::GPIO_DIR: rd_data[GPIO_WIDTH-1:0] = dir_q;
      creator_pkg::GPIO_OUT: rd_data[GPIO_WIDTH-1:0] = out_q;
      creator_pkg::GPIO_IN:  rd_data[GPIO_WIDTH-1:0] = in_sync_q;
      default:               rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      dir_q <= '0;
      out_q <= '0;
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
      if (access && req_i.we) begin
        // GPIO_IN writes fall through to nothing
        if (offset == creator_pkg::GPIO_DIR) dir_q <= req_i.dat[GPIO_WIDTH-1:0];
        if (offset == creator_pkg::GPIO_OUT) out_q <= req_i.dat[GPIO_WIDTH-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    rd_data_q <= rd_data;
  end

  assign rsp_o.ack  = ack_q;
  assign rsp_o.dat  = rd_data_q;
  assign gpio_out_o = out_q;
  assign gpio_oe_o  = dir_q;

endmodule

//--- rtl/creator_bus_top.sv
`timescale 1ns/1ps

module creator_bus_top #(
  parameter logic [63:0]        VERSION      = 64'hBAD2_6032_000A_0001,
  parameter creator_pkg::word_t GAIN_DEFAULT = 16'd3,
  parameter creator_pkg::word_t VOLUME_INIT  = 16'd15,
  parameter int                 GPIO_WIDTH   = 16
) (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  creator_pkg::bus_req_t m0_req_i,
  input  creator_pkg::bus_req_t m1_req_i,
  output creator_pkg::bus_rsp_t m0_rsp_o,
  output creator_pkg::bus_rsp_t m1_rsp_o,
  output creator_pkg::dac_cfg_t dac_cfg_o,
  input  logic [GPIO_WIDTH-1:0] gpio_in_i,
  output logic [GPIO_WIDTH-1:0] gpio_out_o,
  output logic [GPIO_WIDTH-1:0] gpio_oe_o
);

  creator_pkg::bus_req_t bus_req;
  creator_pkg::bus_rsp_t bus_rsp;
  creator_pkg::bus_req_t cfg_req;
  creator_pkg::bus_rsp_t cfg_rsp;
  creator_pkg::bus_req_t gpio_req;
  creator_pkg::bus_rsp_t gpio_rsp;

  // ----------------------------------------
  // Interconnect
  // ----------------------------------------
  bus_arbiter u_arbiter (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .m0_req_i (m0_req_i),
    .m1_req_i (m1_req_i),
    .m0_rsp_o (m0_rsp_o),
    .m1_rsp_o (m1_rsp_o),
    .bus_req_o(bus_req),
    .bus_rsp_i(bus_rsp)
  );

  bus_decoder u_decoder (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp),
    .cfg_req_o (cfg_req),
    .gpio_req_o(gpio_req),
    .cfg_rsp_i (cfg_rsp),
    .gpio_rsp_i(gpio_rsp)
  );

  // ----------------------------------------
  // Slaves
  // ----------------------------------------
  config_regs #(
    .VERSION     (VERSION),
    .GAIN_DEFAULT(GAIN_DEFAULT),
    .VOLUME_INIT (VOLUME_INIT)
  ) u_config (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .req_i    (cfg_req),
    .rsp_o    (cfg_rsp),
    .dac_cfg_o(dac_cfg_o)
  );

  gpio_port #(
    .GPIO_WIDTH(GPIO_WIDTH)
  ) u_gpio (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .req_i     (gpio_req),
    .rsp_o     (gpio_rsp),
    .gpio_in_i (gpio_in_i),
    .gpio_out_o(gpio_out_o),
    .gpio_oe_o (gpio_oe_o)
  );

endmodule

//--- test/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

  // ----------------------------------------
  // Random numbers
  // ----------------------------------------
  logic [31:0] rng_state = 32'h86aab4b1;

  function automatic logic [31:0] xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic creator_pkg::word_t rand_word();
    logic [31:0] r;
    r = xorshift();
    return r[31:16];
  endfunction

  // ----------------------------------------
  // Shadow register model
  // ----------------------------------------
  creator_pkg::word_t    m_gain;
  creator_pkg::word_t    m_volume;
  logic                  m_mute;
  logic                  m_hp_nspk;
  logic [GPIO_WIDTH-1:0] m_dir;
  logic [GPIO_WIDTH-1:0] m_out;
  logic [GPIO_WIDTH-1:0] m_gpio_in;

  function automatic void model_reset();
    m_gain    = GAIN_DEFAULT;
    m_volume  = VOLUME_INIT;
    m_mute    = 1'b0;
    m_hp_nspk = 1'b0;
    m_dir     = '0;
    m_out     = '0;
    m_gpio_in = '0;
  endfunction

  // Select in the top 3 bits, offset in the low 4
  function automatic creator_pkg::addr_t reg_addr(input creator_pkg::slv_sel_t sel,
                                                  input creator_pkg::reg_off_t off);
    return {sel, 8'h00, off};
  endfunction

  function automatic creator_pkg::word_t ref_read(input creator_pkg::addr_t adr);
    creator_pkg::slv_sel_t sel;
    creator_pkg::reg_off_t off;
    creator_pkg::word_t    val;
    sel = adr[14:12];
    off = adr[3:0];
    val = '0;
    if (sel == creator_pkg::SEL_CONFIG) begin
      case (off)
        4'd0, 4'd1, 4'd2, 4'd3: val = VERSION[off*16 +: 16];
        creator_pkg::CFG_MIC_GAIN:   val = m_gain;
        creator_pkg::CFG_DAC_VOLUME: val = m_volume;
        creator_pkg::CFG_DAC_FLAGS:  val = {14'd0, m_hp_nspk, m_mute};
        default:                     val = '0;
      endcase
    end else if (sel == creator_pkg::SEL_GPIO) begin
      case (off)
        creator_pkg::GPIO_DIR: val[GPIO_WIDTH-1:0] = m_dir;
        creator_pkg::GPIO_OUT: val[GPIO_WIDTH-1:0] = m_out;
        creator_pkg::GPIO_IN:  val[GPIO_WIDTH-1:0] = m_gpio_in;
        default:               val = '0;
      endcase
    end
    return val;
  endfunction

  // Version words, spare offsets, GPIO_IN and unmapped space ignore writes
  function automatic void model_write(input creator_pkg::addr_t adr,
                                      input creator_pkg::word_t dat);
    creator_pkg::slv_sel_t sel;
    creator_pkg::reg_off_t off;
    sel = adr[14:12];
    off = adr[3:0];
    if (sel == creator_pkg::SEL_CONFIG) begin
      case (off)
        creator_pkg::CFG_MIC_GAIN:   m_gain = dat;
        creator_pkg::CFG_DAC_VOLUME: m_volume = dat;
        creator_pkg::CFG_DAC_FLAGS: begin
          m_mute    = dat[0];
          m_hp_nspk = dat[1];
        end
        default: ;
      endcase
    end else if (sel == creator_pkg::SEL_GPIO) begin
      if (off == creator_pkg::GPIO_DIR) m_dir = dat[GPIO_WIDTH-1:0];
      if (off == creator_pkg::GPIO_OUT) m_out = dat[GPIO_WIDTH-1:0];
    end
  endfunction

  // ----------------------------------------
  // Bus master
  // ----------------------------------------
  task automatic master_access(input int m, input logic we, input creator_pkg::addr_t adr,
                               input creator_pkg::word_t wdat, output int cycles);
    creator_pkg::bus_req_t req;
    logic                  ack;
    int                    n;
    req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    ack = 1'b0;
    n   = 0;
    @(posedge clk);
    #2;
    if (m == 0) begin
      m0_req_i = req;
    end else begin
      m1_req_i = req;
    end
    while (!ack && n < ACK_TIMEOUT) begin
      @(negedge clk);
      n++;
      ack = (m == 0) ? m0_rsp_o.ack : m1_rsp_o.ack;
    end
    // First edge samples the request, the edge after this negedge takes the ack
    cycles = n - 1;
    assert (ack) else begin
      $display("Master %0d got no acknowledge for address %h", m, adr);
      errors++;
    end
    @(posedge clk);
    #2;
    if (m == 0) begin
      m0_req_i = '0;
    end else begin
      m1_req_i = '0;
    end
  endtask

  task automatic reg_write(input int m, input creator_pkg::slv_sel_t sel,
                           input creator_pkg::reg_off_t off, input creator_pkg::word_t dat);
    int cycles;
    master_access(m, 1'b1, reg_addr(sel, off), dat, cycles);
  endtask

  task automatic reg_read(input int m, input creator_pkg::slv_sel_t sel,
                          input creator_pkg::reg_off_t off);
    int cycles;
    master_access(m, 1'b0, reg_addr(sel, off), '0, cycles);
  endtask

`endif

//--- test/tb_creator_bus.sv
`timescale 1ns/1ps

module tb_creator_bus;

  localparam logic [63:0]        VERSION      = 64'hBAD2_6032_000A_0001;
  localparam creator_pkg::word_t GAIN_DEFAULT = 16'd3;
  localparam creator_pkg::word_t VOLUME_INIT  = 16'd15;
  localparam int                 GPIO_WIDTH   = 16;
  localparam int                 CLK_PERIOD   = 40;
  localparam int                 RESET_CYCLES = 10;
  localparam int                 ACK_TIMEOUT  = 20;
  localparam int                 CONC_TXN     = 20;
  // Bus transactions of all tests together, rounded up
  localparam int                 NUM_TXN      = 140;

  logic                  clk;
  logic                  rst_n_i;
  creator_pkg::bus_req_t m0_req_i;
  creator_pkg::bus_req_t m1_req_i;
  creator_pkg::bus_rsp_t m0_rsp_o;
  creator_pkg::bus_rsp_t m1_rsp_o;
  creator_pkg::dac_cfg_t dac_cfg_o;
  logic [GPIO_WIDTH-1:0] gpio_in_i;
  logic [GPIO_WIDTH-1:0] gpio_out_o;
  logic [GPIO_WIDTH-1:0] gpio_oe_o;

  int errors;
  int tests_run;
  int acks_seen;
  // Master of every ack in bus order
  int ack_log[$];

  `include "tb_tasks.svh"

  creator_bus_top DUT (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .m0_req_i  (m0_req_i),
    .m1_req_i  (m1_req_i),
    .m0_rsp_o  (m0_rsp_o),
    .m1_rsp_o  (m1_rsp_o),
    .dac_cfg_o (dac_cfg_o),
    .gpio_in_i (gpio_in_i),
    .gpio_out_o(gpio_out_o),
    .gpio_oe_o (gpio_oe_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // 20 cycles per transaction is well above the worst contended latency
  initial begin
    #(NUM_TXN * 20 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD);
    $display("Watchdog expired, the bus stopped answering before the tests finished");
    $display("=== FAIL ===");
    $finish;
  end

  // ----------------------------------------
  // Compare process
  // ----------------------------------------
  task automatic check_ack(input int m, input creator_pkg::bus_req_t req,
                           input creator_pkg::bus_rsp_t rsp);
    creator_pkg::word_t exp;
    acks_seen++;
    ack_log.push_back(m);
    if (req.we) begin
      model_write(req.adr, req.dat);
    end else begin
      exp = ref_read(req.adr);
      assert (rsp.dat == exp) else begin
        $display("[ERROR] m%0d_rsp_o.dat at %h: got %h expected %h", m, req.adr, rsp.dat, exp);
        errors++;
      end
    end
  endtask

  task automatic check_outputs();
    creator_pkg::dac_cfg_t exp_cfg;
    exp_cfg = '{mic_gain: m_gain, dac_volume: m_volume, dac_mute: m_mute,
                dac_hp_nspk: m_hp_nspk};
    assert (dac_cfg_o == exp_cfg) else begin
      $display("[ERROR] dac_cfg_o: got %h expected %h", dac_cfg_o, exp_cfg);
      errors++;
    end
    assert (gpio_oe_o == m_dir) else begin
      $display("[ERROR] gpio_oe_o: got %h expected %h", gpio_oe_o, m_dir);
      errors++;
    end
    assert (gpio_out_o == m_out) else begin
      $display("[ERROR] gpio_out_o: got %h expected %h", gpio_out_o, m_out);
      errors++;
    end
  endtask

  // Writes land on the ack edge, so outputs are compared after the model update
  always @(negedge clk) begin
    if (rst_n_i) begin
      if (m0_rsp_o.ack) check_ack(0, m0_req_i, m0_rsp_o);
      if (m1_rsp_o.ack) check_ack(1, m1_req_i, m1_rsp_o);
      check_outputs();
    end
  end

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      $display("Test %0d %s: %0d errors", tests_run, name, errors - err_before);
    end
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic test_reset_state();
    int err_before;
    err_before = errors;
    assert (dac_cfg_o == {GAIN_DEFAULT, VOLUME_INIT, 1'b0, 1'b0}) else begin
      $display("[ERROR] dac_cfg_o after reset: got %h expected %h", dac_cfg_o,
               {GAIN_DEFAULT, VOLUME_INIT, 1'b0, 1'b0});
      errors++;
    end
    assert (gpio_oe_o == '0 && gpio_out_o == '0) else begin
      $display("[ERROR] gpio_oe_o/gpio_out_o after reset: got %h/%h expected %h/%h",
               gpio_oe_o, gpio_out_o, {GPIO_WIDTH{1'b0}}, {GPIO_WIDTH{1'b0}});
      errors++;
    end
    for (int off = 0; off < 7; off++) begin
      reg_read(0, creator_pkg::SEL_CONFIG, creator_pkg::reg_off_t'(off));
    end
    finish_test("reset state", err_before);
  endtask

  task automatic test_config_writes();
    int err_before;
    err_before = errors;
    for (int r = 0; r < 4; r++) begin
      for (int off = 4; off < 7; off++) begin
        reg_write(r % 2, creator_pkg::SEL_CONFIG, creator_pkg::reg_off_t'(off), rand_word());
        reg_read(r % 2, creator_pkg::SEL_CONFIG, creator_pkg::reg_off_t'(off));
      end
    end
    // Version is read-only
    for (int off = 0; off < 4; off++) begin
      reg_write(0, creator_pkg::SEL_CONFIG, creator_pkg::reg_off_t'(off), rand_word());
      reg_read(1, creator_pkg::SEL_CONFIG, creator_pkg::reg_off_t'(off));
    end
    for (int off = 7; off < 16; off++) begin
      reg_read(0, creator_pkg::SEL_CONFIG, creator_pkg::reg_off_t'(off));
    end
    finish_test("config writes", err_before);
  endtask

  task automatic test_gpio();
    int                    err_before;
    logic [GPIO_WIDTH-1:0] pins;
    err_before = errors;
    for (int r = 0; r < 3; r++) begin
      reg_write(r % 2, creator_pkg::SEL_GPIO, creator_pkg::GPIO_DIR, rand_word());
      reg_write(r % 2, creator_pkg::SEL_GPIO, creator_pkg::GPIO_OUT, rand_word());
      reg_read(0, creator_pkg::SEL_GPIO, creator_pkg::GPIO_DIR);
      reg_read(1, creator_pkg::SEL_GPIO, creator_pkg::GPIO_OUT);
      // Hold the pins long enough to pass the two sync flops
      pins = rand_word();
      @(posedge clk);
      #2;
      gpio_in_i = pins;
      m_gpio_in = pins;
      repeat (3) @(posedge clk);
      reg_read(r % 2, creator_pkg::SEL_GPIO, creator_pkg::GPIO_IN);
    end
    reg_write(0, creator_pkg::SEL_GPIO, creator_pkg::GPIO_IN, rand_word());
    reg_read(0, creator_pkg::SEL_GPIO, creator_pkg::GPIO_DIR);
    reg_read(0, creator_pkg::SEL_GPIO, creator_pkg::GPIO_OUT);
    reg_read(1, creator_pkg::SEL_GPIO, creator_pkg::GPIO_IN);
    finish_test("gpio", err_before);
  endtask

  task automatic test_idle_latency();
    int                    err_before;
    int                    cycles;
    creator_pkg::slv_sel_t sel;
    err_before = errors;
    for (int m = 0; m < 2; m++) begin
      for (int s = 0; s < 2; s++) begin
        sel = s ? creator_pkg::SEL_GPIO : creator_pkg::SEL_CONFIG;
        master_access(m, 1'b0, reg_addr(sel, 4'd0), '0, cycles);
        assert (cycles == 2) else begin
          $display("[ERROR] m%0d_rsp_o.ack latency: got %h expected %h", m, cycles, 2);
          errors++;
        end
      end
    end
    finish_test("idle latency", err_before);
  endtask

  task automatic test_concurrent();
    int err_before;
    err_before = errors;
    ack_log.delete();
    fork
      for (int i = 0; i < CONC_TXN; i++) begin : m0_side
        logic [31:0] r;
        int          cycles;
        r = xorshift();
        master_access(0, r[8], reg_addr(creator_pkg::SEL_CONFIG,
                      creator_pkg::reg_off_t'(r[7:0] % 7)), r[31:16], cycles);
      end
      for (int i = 0; i < CONC_TXN; i++) begin : m1_side
        logic [31:0] r;
        int          cycles;
        r = xorshift();
        master_access(1, r[8], reg_addr(creator_pkg::SEL_GPIO,
                      creator_pkg::reg_off_t'(r[7:0] % 3)), r[31:16], cycles);
      end
    join
    assert (ack_log.size() == 2 * CONC_TXN) else begin
      $display("Only %0d of %0d concurrent transactions completed", ack_log.size(), 2 * CONC_TXN);
      errors++;
    end
    for (int i = 1; i < ack_log.size(); i++) begin
      assert (ack_log[i] != ack_log[i-1]) else begin
        $display("Master %0d was served twice in a row while the other waited", ack_log[i]);
        errors++;
      end
    end
    finish_test("concurrent masters", err_before);
  endtask

  task automatic test_unmapped();
    int          err_before;
    logic [31:0] r;
    err_before = errors;
    for (int s = 0; s < 8; s++) begin
      if (s != creator_pkg::SEL_CONFIG && s != creator_pkg::SEL_GPIO) begin
        r = xorshift();
        reg_write(s % 2, creator_pkg::slv_sel_t'(s), creator_pkg::reg_off_t'(r[7:0] % 7),
                  r[31:16]);
        reg_read(s % 2, creator_pkg::slv_sel_t'(s), creator_pkg::reg_off_t'(r[7:0] % 7));
      end
    end
    // Nothing behind the mapped slaves may have moved
    for (int off = 0; off < 7; off++) begin
      reg_read(0, creator_pkg::SEL_CONFIG, creator_pkg::reg_off_t'(off));
    end
    for (int off = 0; off < 3; off++) begin
      reg_read(1, creator_pkg::SEL_GPIO, creator_pkg::reg_off_t'(off));
    end
    finish_test("unmapped addresses", err_before);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    errors    = 0;
    tests_run = 0;
    acks_seen = 0;
    rst_n_i   = 1'b0;
    m0_req_i  = '0;
    m1_req_i  = '0;
    gpio_in_i = '0;
    model_reset();
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n_i = 1'b1;

    test_reset_state();
    test_config_writes();
    test_gpio();
    test_idle_latency();
    test_concurrent();
    test_unmapped();

    $display("Tests run: %0d, transactions: %0d, errors: %0d", tests_run, acks_seen, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+test
rtl/creator_pkg.sv
rtl/bus_arbiter.sv
rtl/bus_decoder.sv
rtl/config_regs.sv
rtl/gpio_port.sv
rtl/creator_bus_top.sv
test/tb_creator_bus.sv

//--- Bender.yml
package:
  name: creator_bus

sources:
  - files:
      - rtl/creator_pkg.sv
      - rtl/bus_arbiter.sv
      - rtl/bus_decoder.sv
      - rtl/config_regs.sv
      - rtl/gpio_port.sv
      - rtl/creator_bus_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_creator_bus.sv
